//--- build.f
logic/mem_pkg.sv
logic/dual_port_ram.sv
logic/bus_decoder.sv
logic/ctl_reg_bank.sv
logic/mod_buffer.sv
logic/duty_table.sv
logic/mod_sampler.sv
logic/memory_top.sv
tests/memory_tb.sv

//--- logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic              bus_clk,
  input  logic              arst_n,
  input  mem_pkg::host_req_t req,
  output logic              ctl_en,
  output logic              mod_en,
  output logic              duty_en,
  input  logic [15:0]       ctl_rdata,
  input  logic [15:0]       mod_rdata,
  input  logic [15:0]       duty_rdata,
  output logic [15:0]       rdata
);

  logic [5:0]       ctl_sel;
  logic             rd_valid;
  mem_pkg::region_e rd_region;

  assign ctl_sel = req.addr[13:8];

  // Controller area only decodes on its main select
  assign ctl_en  = req.en && (req.region == mem_pkg::REGION_CTL) &&
                   (ctl_sel == mem_pkg::CTL_SEL_MAIN);
  assign mod_en  = req.en && (req.region == mem_pkg::REGION_MOD);
  assign duty_en = req.en && (req.region == mem_pkg::REGION_DUTY);

  // Remember which region the read went to
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid  <= 1'b0;
      rd_region <= mem_pkg::REGION_CTL;
    end else begin
      rd_valid  <= (ctl_en || mod_en || duty_en) && !req.we;
      rd_region <= req.region;
    end
  end

  // Steer returning RAM data
  always_comb begin
    rdata = '0;
    if (rd_valid) begin
      case (rd_region)
        mem_pkg::REGION_CTL:  rdata = ctl_rdata;
        mem_pkg::REGION_MOD:  rdata = mod_rdata;
        mem_pkg::REGION_DUTY: rdata = duty_rdata;
        default:              rdata = '0;
      endcase
    end
  end

  // Host must never use the reserved region
  a_no_rsvd_region: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    req.en |-> (req.region != mem_pkg::REGION_RSVD)
  );

endmodule

//--- logic/ctl_reg_bank.sv
`timescale 1ns/1ps

module ctl_reg_bank (
  input  logic               bus_clk,
  input  logic               arst_n,
  input  logic               en,
  input  mem_pkg::host_req_t req,
  output logic [15:0]        rdata,
  output mem_pkg::cfg_t      cfg
);

  logic       wr_now;
  logic [2:0] wr_hist;

  assign wr_now = en && req.we;

  // Readback store for the controller words
  dual_port_ram #(
    .width(16),
    .depth(mem_pkg::CTL_DEPTH)
  ) ctl_ram_i (
    .bus_clk (bus_clk),
    .a_en    (en),
    .a_we    (req.we),
    .a_addr  (req.addr[7:0]),
    .a_wdata (req.wdata),
    .a_rdata (rdata),
    .b_addr  ('0),
    .b_rdata ()
  );

  // Latch cfg on the third cycle of a held write
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_hist <= '0;
      cfg     <= '0;
    end else begin
      wr_hist <= {wr_hist[1:0], wr_now};
      if (wr_now && (wr_hist == 3'b011)) begin
        case (req.addr[7:0])
          mem_pkg::ADDR_MOD_WR_SEGMENT: cfg.mod_wr_segment <= req.wdata[0];
          mem_pkg::ADDR_MOD_RD_SEGMENT: cfg.mod_rd_segment <= req.wdata[0];
          mem_pkg::ADDR_MOD_CYCLE:      cfg.mod_cycle      <= req.wdata[14:0];
          mem_pkg::ADDR_MOD_FREQ_DIV:   cfg.mod_freq_div   <= req.wdata;
          mem_pkg::ADDR_DUTY_WR_PAGE:   cfg.duty_wr_page   <= req.wdata[0];
          mem_pkg::ADDR_INTENSITY:      cfg.intensity      <= req.wdata[7:0];
          default: begin
          end
        endcase
      end
    end
  end

  // Address held while the cfg update is pending
  a_addr_stable: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    (wr_now && wr_hist[0] && !wr_hist[2]) |-> $stable(req.addr)
  );

endmodule

//--- logic/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int width = 16,
  parameter int depth = 256
) (
  input  logic                     bus_clk,
  input  logic                     a_en,
  input  logic                     a_we,
  input  logic [$clog2(depth)-1:0] a_addr,
  input  logic [width-1:0]         a_wdata,
  output logic [width-1:0]         a_rdata,
  input  logic [$clog2(depth)-1:0] b_addr,
  output logic [width-1:0]         b_rdata
);

  logic [width-1:0] mem [depth];

  // Port A reads before it writes
  always_ff @(posedge bus_clk) begin
    if (a_en) begin
      a_rdata <= mem[a_addr];
      if (a_we) begin
        mem[a_addr] <= a_wdata;
      end
    end
  end

  // Port B reads every cycle
  always_ff @(posedge bus_clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule

//--- logic/duty_table.sv
`timescale 1ns/1ps

module duty_table (
  input  logic               bus_clk,
  input  logic               en,
  input  mem_pkg::host_req_t req,
  input  logic               wr_page,
  output logic [15:0]        rdata,
  input  logic [15:0]        idx,
  output logic [7:0]         width
);

  logic [15:0] entry_word;
  logic        hi_q;

  // Bus addresses land in the selected page
  dual_port_ram #(
    .width(16),
    .depth(mem_pkg::DUTY_WORDS)
  ) duty_ram_i (
    .bus_clk (bus_clk),
    .a_en    (en),
    .a_we    (req.we),
    .a_addr  ({wr_page, req.addr}),
    .a_wdata (req.wdata),
    .a_rdata (rdata),
    .b_addr  (idx[15:1]),
    .b_rdata (entry_word)
  );

  always_ff @(posedge bus_clk) begin
    hi_q <= idx[0];
  end

  // Odd entries in the upper byte
  assign width = hi_q ? entry_word[15:8] : entry_word[7:0];

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

  // Host bus region select with code 3 reserved
  typedef enum logic [1:0] {
    REGION_CTL  = 2'd0,
    REGION_MOD  = 2'd1,
    REGION_DUTY = 2'd2,
    REGION_RSVD = 2'd3
  } region_e;

  typedef struct packed {
    logic        en;
    logic        we;
    region_e     region;
    logic [13:0] addr;
    logic [15:0] wdata;
  } host_req_t;

  // Configuration latched from controller writes
  typedef struct packed {
    logic        mod_wr_segment;
    logic        mod_rd_segment;
    logic [14:0] mod_cycle;
    logic [15:0] mod_freq_div;
    logic        duty_wr_page;
    logic [7:0]  intensity;
  } cfg_t;

  typedef struct packed {
    logic        valid;
    logic        segment;
    logic [14:0] idx;
    logic [7:0]  width;
  } pulse_t;

  // Controller area select on addr[13:8]
  localparam logic [5:0] CTL_SEL_MAIN = 6'h00;

  localparam logic [7:0] ADDR_MOD_WR_SEGMENT = 8'h20;
  localparam logic [7:0] ADDR_MOD_RD_SEGMENT = 8'h21;
  localparam logic [7:0] ADDR_MOD_CYCLE      = 8'h22;
  localparam logic [7:0] ADDR_MOD_FREQ_DIV   = 8'h23;
  localparam logic [7:0] ADDR_DUTY_WR_PAGE   = 8'h24;
  localparam logic [7:0] ADDR_INTENSITY      = 8'h25;

  localparam int CTL_DEPTH  = 256;
  // Two 8-bit samples per word
  localparam int MOD_WORDS  = 16384;
  // Two pages of 16384 words with two entries per word
  localparam int DUTY_WORDS = 32768;

endpackage

//--- logic/memory_top.sv
`timescale 1ns/1ps

module memory_top (
  input  logic               bus_clk,
  input  logic               arst_n,
  input  mem_pkg::host_req_t host_req,
  output logic [15:0]        rdata,
  output mem_pkg::pulse_t    pulse
);

  logic          ctl_en;
  logic          mod_en;
  logic          duty_en;
  logic [15:0]   ctl_rdata;
  logic [15:0]   mod_rdata;
  logic [15:0]   duty_rdata;
  mem_pkg::cfg_t cfg;
  logic [14:0]   mod_idx;
  logic          rd_segment;
  logic [7:0]    sample;
  logic [15:0]   duty_idx;
  logic [7:0]    width;

  bus_decoder bus_decoder_i (
    .bus_clk    (bus_clk),
    .arst_n     (arst_n),
    .req        (host_req),
    .ctl_en     (ctl_en),
    .mod_en     (mod_en),
    .duty_en    (duty_en),
    .ctl_rdata  (ctl_rdata),
    .mod_rdata  (mod_rdata),
    .duty_rdata (duty_rdata),
    .rdata      (rdata)
  );

  ctl_reg_bank ctl_reg_bank_i (
    .bus_clk (bus_clk),
    .arst_n  (arst_n),
    .en      (ctl_en),
    .req     (host_req),
    .rdata   (ctl_rdata),
    .cfg     (cfg)
  );

  mod_buffer mod_buffer_i (
    .bus_clk    (bus_clk),
    .en         (mod_en),
    .req        (host_req),
    .wr_segment (cfg.mod_wr_segment),
    .rdata      (mod_rdata),
    .rd_idx     (mod_idx),
    .rd_segment (rd_segment),
    .sample     (sample)
  );

  duty_table duty_table_i (
    .bus_clk (bus_clk),
    .en      (duty_en),
    .req     (host_req),
    .wr_page (cfg.duty_wr_page),
    .rdata   (duty_rdata),
    .idx     (duty_idx),
    .width   (width)
  );

  mod_sampler mod_sampler_i (
    .bus_clk    (bus_clk),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .mod_idx    (mod_idx),
    .rd_segment (rd_segment),
    .sample     (sample),
    .duty_idx   (duty_idx),
    .width      (width),
    .pulse      (pulse)
  );

endmodule

//--- logic/mod_buffer.sv
`timescale 1ns/1ps

module mod_buffer (
  input  logic               bus_clk,
  input  logic               en,
  input  mem_pkg::host_req_t req,
  input  logic               wr_segment,
  output logic [15:0]        rdata,
  input  logic [14:0]        rd_idx,
  input  logic               rd_segment,
  output logic [7:0]         sample
);

  logic [15:0] bus_word [2];
  logic [15:0] seg_word [2];
  logic        bus_seg_q;
  logic        rd_seg_q;
  logic        rd_hi_q;
  logic [15:0] rd_word;

  // One RAM per segment with only the write segment on the bus
  for (genvar s = 0; s < 2; s++) begin : g_seg
    dual_port_ram #(
      .width(16),
      .depth(mem_pkg::MOD_WORDS)
    ) seg_ram_i (
      .bus_clk (bus_clk),
      .a_en    (en && (wr_segment == 1'(s))),
      .a_we    (req.we),
      .a_addr  (req.addr),
      .a_wdata (req.wdata),
      .a_rdata (bus_word[s]),
      .b_addr  (rd_idx[14:1]),
      .b_rdata (seg_word[s])
    );
  end

  // Select info follows the read latency
  always_ff @(posedge bus_clk) begin
    if (en) begin
      bus_seg_q <= wr_segment;
    end
    rd_seg_q <= rd_segment;
    rd_hi_q  <= rd_idx[0];
  end

  assign rdata   = bus_word[bus_seg_q];
  assign rd_word = seg_word[rd_seg_q];

  // Odd samples sit in the upper byte
  assign sample = rd_hi_q ? rd_word[15:8] : rd_word[7:0];

endmodule

//--- logic/mod_sampler.sv
`timescale 1ns/1ps

module mod_sampler (
  input  logic                bus_clk,
  input  logic                arst_n,
  input  mem_pkg::cfg_t       cfg,
  output logic [14:0]         mod_idx,
  output logic                rd_segment,
  input  logic [7:0]          sample,
  output logic [15:0]         duty_idx,
  input  logic [7:0]          width,
  output mem_pkg::pulse_t     pulse
);

  logic [15:0] div_cnt;
  logic        step;
  logic        wrap;
  logic [14:0] idx_q;
  logic        seg_q;

  // Lookup pipeline where stage 1 waits on the sample and stage 2 on the width
  logic        v1;
  logic        seg1;
  logic [14:0] idx1;
  logic        v2;
  logic        seg2;
  logic [14:0] idx2;

  assign step = (div_cnt >= cfg.mod_freq_div);
  assign wrap = (idx_q >= cfg.mod_cycle);

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      idx_q   <= '0;
      seg_q   <= 1'b0;
    end else if (step) begin
      div_cnt <= '0;
      if (wrap) begin
        idx_q <= '0;
        // New segment only from sample 0
        seg_q <= cfg.mod_rd_segment;
      end else begin
        idx_q <= idx_q + 15'd1;
      end
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  assign mod_idx    = idx_q;
  assign rd_segment = seg_q;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= step;
      v2 <= v1;
    end
  end

  always_ff @(posedge bus_clk) begin
    seg1 <= seg_q;
    idx1 <= idx_q;
    seg2 <= seg1;
    idx2 <= idx1;
  end

  // Intensity selects the 256-entry row
  assign duty_idx = {cfg.intensity, sample};

  assign pulse = '{valid: v2, segment: seg2, idx: idx2, width: width};

  // Back-to-back pulses need a zero divider two cycles earlier
  a_pulse_spacing: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    (pulse.valid && $past(pulse.valid)) |-> ($past(cfg.mod_freq_div, 2) == '0)
  );

endmodule

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module memory_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vmemory_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- tests/memory_tb.sv
`timescale 1ns/1ps

module memory_tb;

  logic               bus_clk;
  logic               arst_n;
  mem_pkg::host_req_t host_req;
  logic [15:0]        rdata;
  mem_pkg::pulse_t    pulse;

  // Reference copies of the configuration and both memories
  mem_pkg::cfg_t cfg_model;
  logic [7:0]    mod_model [2][32768];
  logic [7:0]    duty_model [65536];
  logic [31:0]   lfsr_state = 32'hbf76ab2c;
  int            cyc = 0;
  int            checks = 0;
  int            errors = 0;

  memory_top memory_top_i (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .host_req (host_req),
    .rdata    (rdata),
    .pulse    (pulse)
  );

  always #50 bus_clk = ~bus_clk;

  always @(posedge bus_clk) begin
    cyc <= cyc + 1;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Held for three cycles and then one idle cycle
  task automatic bus_write(input mem_pkg::region_e rgn, input logic [13:0] addr,
                           input logic [15:0] data);
    host_req = '{en: 1'b1, we: 1'b1, region: rgn, addr: addr, wdata: data};
    repeat (3) @(negedge bus_clk);
    host_req = '0;
    @(negedge bus_clk);
  endtask

  task automatic bus_read(input mem_pkg::region_e rgn, input logic [13:0] addr,
                          output logic [15:0] data);
    host_req = '{en: 1'b1, we: 1'b0, region: rgn, addr: addr, wdata: 16'h0};
    @(negedge bus_clk);
    data = rdata;
    host_req = '0;
  endtask

  task automatic write_cfg(input logic [7:0] addr, input logic [15:0] value);
    bus_write(mem_pkg::REGION_CTL, {mem_pkg::CTL_SEL_MAIN, addr}, value);
    case (addr)
      mem_pkg::ADDR_MOD_WR_SEGMENT: cfg_model.mod_wr_segment = value[0];
      mem_pkg::ADDR_MOD_RD_SEGMENT: cfg_model.mod_rd_segment = value[0];
      mem_pkg::ADDR_MOD_CYCLE:      cfg_model.mod_cycle = value[14:0];
      mem_pkg::ADDR_MOD_FREQ_DIV:   cfg_model.mod_freq_div = value;
      mem_pkg::ADDR_DUTY_WR_PAGE:   cfg_model.duty_wr_page = value[0];
      mem_pkg::ADDR_INTENSITY:      cfg_model.intensity = value[7:0];
      default: begin
      end
    endcase
  endtask

  task automatic wait_pulse(output int t);
    int n;
    n = 0;
    do begin
      @(negedge bus_clk);
      n++;
    end while (!pulse.valid && n < 64);
    if (pulse.valid) begin
      t = cyc;
    end else begin
      errors++;
      $display("Timeout: no valid pulse within 64 cycles");
      end_run();
    end
  endtask

  // Two samples per word with the even sample in the low byte
  task automatic fill_mod(input logic seg, input int nwords);
    logic [15:0] w;
    logic [13:0] a;
    for (int i = 0; i < nwords; i++) begin
      a = 14'(i);
      w = rand_bits(16);
      bus_write(mem_pkg::REGION_MOD, a, w);
      mod_model[seg][{a, 1'b0}] = w[7:0];
      mod_model[seg][{a, 1'b1}] = w[15:8];
    end
  endtask

  // One 256-entry row on the page set by the top intensity bit
  task automatic fill_duty_row(input logic [7:0] inten);
    logic [15:0] w;
    logic [14:0] word;
    write_cfg(mem_pkg::ADDR_DUTY_WR_PAGE, {15'd0, inten[7]});
    for (int i = 0; i < 128; i++) begin
      word = {inten, 7'(i)};
      w = rand_bits(16);
      bus_write(mem_pkg::REGION_DUTY, word[13:0], w);
      duty_model[{word, 1'b0}] = w[7:0];
      duty_model[{word, 1'b1}] = w[15:8];
    end
  endtask

  task automatic check_pulses(input int n, input int skip, input logic seg_before,
                              input logic seg_after);
    int          t;
    int          t_prev;
    logic [14:0] prev;
    logic [14:0] exp_idx;
    logic        wrapped;
    logic        exp_seg;
    logic [7:0]  s;
    t_prev = -1;
    prev = '0;
    wrapped = 1'b0;
    for (int i = 0; i < skip + n; i++) begin
      wait_pulse(t);
      if (i >= skip) begin
        if (t_prev >= 0) begin
          exp_idx = (prev == cfg_model.mod_cycle) ? 15'd0 : prev + 15'd1;
          check_value("pulse.idx", 32'(pulse.idx), 32'(exp_idx));
          check_value("pulse period", 32'(t - t_prev), 32'(cfg_model.mod_freq_div) + 32'd1);
        end
        // Segment switch only shows from sample 0
        if (pulse.idx == 15'd0) begin
          wrapped = 1'b1;
        end
        exp_seg = wrapped ? seg_after : seg_before;
        check_value("pulse.segment", 32'(pulse.segment), 32'(exp_seg));
        s = mod_model[exp_seg][pulse.idx];
        check_value("pulse.width", 32'(pulse.width), 32'(duty_model[{cfg_model.intensity, s}]));
      end
      prev = pulse.idx;
      t_prev = t;
    end
  endtask

  task automatic test_reset();
    repeat (5) begin
      @(negedge bus_clk);
      check_value("pulse.valid", 32'(pulse.valid), 32'h0);
      check_value("rdata", 32'(rdata), 32'h0);
    end
    arst_n = 1'b1;
    @(negedge bus_clk);
    check_value("pulse.valid", 32'(pulse.valid), 32'h0);
    check_value("rdata", 32'(rdata), 32'h0);
  endtask

  task automatic test_ctl_readback();
    logic [15:0] w [8];
    logic [15:0] got;
    logic [7:0]  a;
    for (int i = 0; i < 8; i++) begin
      a = 8'h40 + 8'(i);
      w[i] = rand_bits(16);
      bus_write(mem_pkg::REGION_CTL, {mem_pkg::CTL_SEL_MAIN, a}, w[i]);
    end
    for (int i = 0; i < 8; i++) begin
      a = 8'h40 + 8'(i);
      bus_read(mem_pkg::REGION_CTL, {mem_pkg::CTL_SEL_MAIN, a}, got);
      check_value("rdata", 32'(got), 32'(w[i]));
    end
  endtask

  task automatic test_lookup();
    write_cfg(mem_pkg::ADDR_MOD_WR_SEGMENT, 16'h0);
    fill_mod(1'b0, 8);
    fill_duty_row(8'h05);
    fill_duty_row(8'h33);
    write_cfg(mem_pkg::ADDR_MOD_CYCLE, 16'd15);
    write_cfg(mem_pkg::ADDR_MOD_FREQ_DIV, 16'd2);
    write_cfg(mem_pkg::ADDR_INTENSITY, 16'h0005);
    check_pulses(20, 3, 1'b0, 1'b0);
    // New intensity moves the lookup to another row
    write_cfg(mem_pkg::ADDR_INTENSITY, 16'h0033);
    check_pulses(20, 3, 1'b0, 1'b0);
  endtask

  task automatic test_double_buffer();
    int t;
    int n;
    write_cfg(mem_pkg::ADDR_MOD_WR_SEGMENT, 16'h1);
    fill_mod(1'b1, 8);
    // Switch mid-cycle well away from the wrap
    n = 0;
    do begin
      wait_pulse(t);
      n++;
    end while (pulse.idx != 15'd7 && n < 64);
    if (pulse.idx != 15'd7) begin
      errors++;
      $display("Sample index 7 never appeared on the pulse output");
    end
    write_cfg(mem_pkg::ADDR_MOD_RD_SEGMENT, 16'h1);
    check_pulses(24, 0, 1'b0, 1'b1);
  endtask

  task automatic test_duty_page();
    logic [15:0] got;
    logic [13:0] a;
    logic        pg;
    // Rows 0x1a and 0x9a share bus addresses on different pages
    fill_duty_row(8'h1a);
    fill_duty_row(8'h9a);
    write_cfg(mem_pkg::ADDR_INTENSITY, 16'h009a);
    check_pulses(20, 3, 1'b1, 1'b1);
    for (int p = 1; p >= 0; p--) begin
      pg = 1'(p);
      write_cfg(mem_pkg::ADDR_DUTY_WR_PAGE, {15'd0, pg});
      for (int i = 0; i < 4; i++) begin
        a = {7'h1a, 7'(i)};
        bus_read(mem_pkg::REGION_DUTY, a, got);
        check_value("rdata", 32'(got),
                    32'({duty_model[{pg, a, 1'b1}], duty_model[{pg, a, 1'b0}]}));
      end
    end
    // Bus side of the modulation region follows the write segment
    for (int i = 0; i < 8; i++) begin
      a = 14'(i);
      bus_read(mem_pkg::REGION_MOD, a, got);
      check_value("rdata", 32'(got), 32'({mod_model[1][{a, 1'b1}], mod_model[1][{a, 1'b0}]}));
    end
  endtask

  task automatic test_short_write();
    logic [15:0] got;
    host_req = '{en: 1'b1, we: 1'b1, region: mem_pkg::REGION_CTL,
                 addr: {mem_pkg::CTL_SEL_MAIN, mem_pkg::ADDR_INTENSITY}, wdata: 16'h0005};
    @(negedge bus_clk);
    host_req = '0;
    @(negedge bus_clk);
    bus_read(mem_pkg::REGION_CTL, {mem_pkg::CTL_SEL_MAIN, mem_pkg::ADDR_INTENSITY}, got);
    check_value("rdata", 32'(got), 32'h0005);
    // Intensity stays at 0x9a
    check_pulses(20, 3, 1'b1, 1'b1);
  endtask

  initial begin
    bus_clk = 1'b0;
    arst_n = 1'b0;
    host_req = '0;
    cfg_model = '0;
    test_reset();
    test_ctl_readback();
    test_lookup();
    test_double_buffer();
    test_duty_page();
    test_short_write();
    end_run();
  end

endmodule
